// ==== execute.f ====
rtl/execute_pkg.sv
rtl/exec_ctrl.sv
rtl/exec_alu.sv
rtl/exec_branch.sv
rtl/exec_result.sv
rtl/execute.sv
testbench/tb_clock.sv
testbench/execute_asserts.sv
testbench/tb_execute.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f execute.f --top-module tb_execute -o tb_execute
out=$(./obj_dir/tb_execute)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q 'All tests passed!'; then
    exit 0
fi
exit 1

// ==== testbench/tb_execute.sv ====
`timescale 1ns/10ps

module tb_execute import execute_pkg::*; ();

    localparam int WAIT_LIMIT = 8;

    logic            clk;
    logic            rst_n;
    logic            en;
    exec_req_t       req;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] result_sec;
    logic            valid;
    integer          seed = 86;
    int              tests = 0;
    int              checks = 0;
    int              errors = 0;
    int              errors_before = 0; // Count when the current test started.

    // Equal, smaller and larger in both signed and unsigned sense, plus a shift above 31.
    logic [XLEN-1:0] a_vals [7] = '{32'h0, 32'h1, 32'h2, 32'hffff_ffff, 32'h1,
                                    32'h7fff_ffff, 32'h8000_0001};
    logic [XLEN-1:0] b_vals [7] = '{32'h0, 32'h2, 32'h1, 32'h1, 32'hffff_ffff,
                                    32'h8000_0000, 32'h0000_0024};

    tb_clock u_clock (.clk_o(clk));

    execute #(.XLEN(XLEN)) dut (
        .i_clk              (clk),
        .rst_n_i            (rst_n),
        .en_i               (en),
        .req_i              (req),
        .result_o           (result),
        .result_secondary_o (result_sec),
        .valid_o            (valid)
    );

    function automatic logic [XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic exec_req_t make_req(input instr_e ins, input logic [XLEN-1:0] op1,
                                           input logic [XLEN-1:0] op2);
        exec_req_t r;
        r.instr    = ins;
        r.operand1 = op1;
        r.operand2 = op2;
        r.imm      = rand_word();
        r.imm      = {{(XLEN-12){r.imm[11]}}, r.imm[11:0]}; // Sign-extended 12-bit field.
        r.pc       = rand_word();
        r.pc[1:0]  = 2'b00;
        return r;
    endfunction

    // Expected results from the instruction rules.
    task automatic predict(input exec_req_t r, output logic [XLEN-1:0] res,
                           output logic [XLEN-1:0] sec);
        logic [XLEN-1:0] b;
        b = r.instr inside {[INSTR_ADDI:INSTR_SW]} ? r.imm : r.operand2;
        case (r.instr)
            INSTR_ADD, INSTR_ADDI, INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
            INSTR_SB, INSTR_SH, INSTR_SW: res = r.operand1 + b;
            INSTR_SUB:               res = r.operand1 - b;
            INSTR_XOR, INSTR_XORI:   res = r.operand1 ^ b;
            INSTR_OR, INSTR_ORI:     res = r.operand1 | b;
            INSTR_AND, INSTR_ANDI:   res = r.operand1 & b;
            INSTR_SLL, INSTR_SLLI:   res = r.operand1 << b[4:0];
            INSTR_SRL, INSTR_SRLI:   res = r.operand1 >> b[4:0];
            INSTR_SRA, INSTR_SRAI:   res = $signed(r.operand1) >>> b[4:0];
            INSTR_SLT, INSTR_SLTI:   res = XLEN'($signed(r.operand1) < $signed(b));
            INSTR_SLTU, INSTR_SLTIU: res = XLEN'(r.operand1 < b);
            INSTR_BEQ:               res = XLEN'(r.operand1 == b);
            INSTR_BNE:               res = XLEN'(r.operand1 != b);
            INSTR_BLT:               res = XLEN'($signed(r.operand1) < $signed(b));
            INSTR_BGE:               res = XLEN'($signed(r.operand1) >= $signed(b));
            INSTR_BLTU:              res = XLEN'(r.operand1 < b);
            INSTR_BGEU:              res = XLEN'(r.operand1 >= b);
            INSTR_JAL, INSTR_JALR:   res = r.pc + 32'd4;
            INSTR_AUIPC:             res = r.pc + r.imm;
            INSTR_LUI:               res = r.imm;
            default:                 res = '0;
        endcase
        case (r.instr)
            INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE, INSTR_BLTU, INSTR_BGEU,
            INSTR_JAL:  sec = r.pc + r.imm;
            INSTR_JALR: sec = r.operand1 + r.imm;
            default:    sec = '0;
        endcase
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("%s finished with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    // One strobed request, then wait for valid_o and check both results.
    task automatic run_request(input exec_req_t r);
        logic [XLEN-1:0] exp_res;
        logic [XLEN-1:0] exp_sec;
        int              cycles;
        predict(r, exp_res, exp_sec);
        @(posedge clk);
        #1;
        req    = r;
        en     = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            en = 1'b0;
            cycles++;
        end while (!valid && cycles < WAIT_LIMIT);
        if (!valid) begin
            errors++;
            $display("Timeout at %0t: valid_o never rose after a request", $time);
        end else begin
            check_word("result_o", result, exp_res);
            check_word("result_secondary_o", result_sec, exp_sec);
        end
    endtask

    // Reset holds all outputs at zero while a request is strobed.
    task automatic test_reset();
        check_bit("valid_o", valid, 1'b0);
        check_word("result_o", result, '0);
        check_word("result_secondary_o", result_sec, '0);
        en    = 1'b0;
        req   = '0;
        rst_n = 1'b1;
        for (int n = 0; n < 3; n++) begin
            @(posedge clk);
            #1;
            check_bit("valid_o", valid, 1'b0);
            check_word("result_o", result, '0);
            check_word("result_secondary_o", result_sec, '0);
        end
        report_test("test_reset");
    endtask

    // Every code from first to last over the fixed pairs and a few random ones.
    task automatic test_ops(input string name, input int first, input int last);
        for (int k = first; k <= last; k++) begin
            foreach (a_vals[p]) begin
                run_request(make_req(instr_e'(6'(k)), a_vals[p], b_vals[p]));
            end
            for (int n = 0; n < 3; n++) begin
                run_request(make_req(instr_e'(6'(k)), rand_word(), rand_word()));
            end
        end
        report_test(name);
    endtask

    task automatic test_stream();
        exec_req_t       prev_req;
        logic            prev_en;
        logic [XLEN-1:0] exp_res;
        logic [XLEN-1:0] exp_sec;
        prev_req = '0;
        prev_en  = 1'b0;
        for (int n = 0; n <= 30; n++) begin
            @(posedge clk);
            #1;
            check_bit("valid_o", valid, prev_en);
            if (prev_en) begin
                predict(prev_req, exp_res, exp_sec);
                check_word("result_o", result, exp_res);
                check_word("result_secondary_o", result_sec, exp_sec);
            end
            req      = make_req(instr_e'(6'(rand_word() % 38)), rand_word(), rand_word());
            en       = (n < 30) && (rand_word() % 4 != 0); // Gap in about one cycle of four.
            prev_req = req;
            prev_en  = en;
        end
        report_test("test_stream");
    endtask

    initial begin
        rst_n = 1'b0;
        en    = 1'b1;
        req   = make_req(INSTR_JAL, rand_word(), rand_word());
        repeat (2) @(posedge clk);
        #1;
        test_reset();
        test_ops("test_reg_alu", INSTR_ADD, INSTR_SLTU);
        test_ops("test_imm_mem", INSTR_ADDI, INSTR_SW);
        test_ops("test_branch", INSTR_BEQ, INSTR_BGEU);
        test_ops("test_jump_upper", INSTR_JAL, INSTR_AUIPC);
        test_ops("test_unknown", 38, 64); // Code 64 wraps to INSTR_UNKNOWN.
        test_stream();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== testbench/execute_asserts.sv ====
`timescale 1ns/10ps

module execute_asserts import execute_pkg::*; #(
    parameter int XLEN = 32
) (
    input logic            clk_i,
    input logic            rst_n_i,
    input logic            en_i,
    input exec_req_t       req_i,
    input logic            valid_i,
    input logic [XLEN-1:0] result_i
);

    logic req_branch;

    assign req_branch = req_i.instr inside {[INSTR_BEQ:INSTR_BGEU]};

    valid_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !valid_i)
        else $error("valid_o high while in reset");

    valid_follows_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> valid_i == $past(en_i))
        else $error("valid_o does not match en_i of the previous cycle");

    // A branch leaves only the taken bit in result_o.
    branch_result_is_bit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && $past(req_branch) |-> result_i[XLEN-1:1] == '0)
        else $error("Upper bits of result_o set after a branch");

endmodule

bind execute execute_asserts #(.XLEN(XLEN)) u_asserts (
    .clk_i    (i_clk),
    .rst_n_i  (rst_n_i),
    .en_i     (en_i),
    .req_i    (req_i),
    .valid_i  (valid_o),
    .result_i (result_o)
);

// ==== testbench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 5 // 10 ns period.
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

endmodule

// ==== rtl/execute.sv ====
`timescale 1ns/10ps

module execute import execute_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            i_clk,
    input  logic            rst_n_i,
    input  logic            en_i,
    input  exec_req_t       req_i,
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] result_secondary_o,
    output logic            valid_o
);

    exec_ctrl_t      ctrl;
    logic [XLEN-1:0] alu_res;
    logic            taken;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] target;

    exec_ctrl u_ctrl (
        .i_clk   (i_clk),
        .rst_n_i (rst_n_i),
        .en_i    (en_i),
        .instr_i (req_i.instr),
        .ctrl_o  (ctrl),
        .valid_o (valid_o)
    );

    exec_alu #(.XLEN(XLEN)) u_alu (
        .ctrl_i     (ctrl),
        .operand1_i (req_i.operand1),
        .operand2_i (req_i.operand2),
        .imm_i      (req_i.imm),
        .pc_i       (req_i.pc),
        .result_o   (alu_res)
    );

    exec_branch #(.XLEN(XLEN)) u_branch (
        .ctrl_i     (ctrl),
        .operand1_i (req_i.operand1),
        .operand2_i (req_i.operand2),
        .imm_i      (req_i.imm),
        .pc_i       (req_i.pc),
        .taken_o    (taken),
        .link_o     (link),
        .target_o   (target)
    );

    exec_result #(.XLEN(XLEN)) u_result (
        .i_clk              (i_clk),
        .rst_n_i            (rst_n_i),
        .ctrl_i             (ctrl),
        .alu_res_i          (alu_res),
        .taken_i            (taken),
        .link_i             (link),
        .target_i           (target),
        .imm_i              (req_i.imm),
        .result_o           (result_o),
        .result_secondary_o (result_secondary_o)
    );

endmodule

// ==== rtl/exec_result.sv ====
`timescale 1ns/10ps

module exec_result import execute_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            i_clk,
    input  logic            rst_n_i,
    input  exec_ctrl_t      ctrl_i,
    input  logic [XLEN-1:0] alu_res_i,
    input  logic            taken_i,
    input  logic [XLEN-1:0] link_i,
    input  logic [XLEN-1:0] target_i,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] result_secondary_o
);

    logic [XLEN-1:0] result_d;
    logic [XLEN-1:0] secondary_d;

    always_comb begin
        case (ctrl_i.res_sel)
            RES_ALU:   result_d = alu_res_i;
            RES_LINK:  result_d = link_i;
            RES_TAKEN: result_d = {{(XLEN-1){1'b0}}, taken_i}; // Taken bit in bit 0.
            RES_IMM:   result_d = imm_i;
            default:   result_d = '0;
        endcase
        secondary_d = (ctrl_i.sec_sel == SEC_ZERO) ? '0 : target_i;
    end

    // Captured every edge; en_i only qualifies the result through valid_o.
    always_ff @(posedge i_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o           <= '0;
            result_secondary_o <= '0;
        end else begin
            result_o           <= result_d;
            result_secondary_o <= secondary_d;
        end
    end

endmodule

// ==== rtl/exec_branch.sv ====
`timescale 1ns/10ps

module exec_branch import execute_pkg::*; #(
    parameter int XLEN = 32
) (
    input  exec_ctrl_t      ctrl_i,
    input  logic [XLEN-1:0] operand1_i,
    input  logic [XLEN-1:0] operand2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    output logic            taken_o,
    output logic [XLEN-1:0] link_o,
    output logic [XLEN-1:0] target_o
);

    logic [XLEN-1:0] base;

    always_comb begin
        case (ctrl_i.cmp)
            CMP_EQ:  taken_o = operand1_i == operand2_i;
            CMP_NE:  taken_o = operand1_i != operand2_i;
            CMP_LT:  taken_o = $signed(operand1_i) <  $signed(operand2_i);
            CMP_GE:  taken_o = $signed(operand1_i) >= $signed(operand2_i);
            CMP_LTU: taken_o = operand1_i <  operand2_i;
            CMP_GEU: taken_o = operand1_i >= operand2_i;
            default: taken_o = 1'b0;
        endcase
    end

    assign link_o = pc_i + XLEN'(4); // Return address for JAL and JALR.

    // JALR jumps relative to rs1, everything else relative to the pc.
    assign base     = (ctrl_i.sec_sel == SEC_RS1_IMM) ? operand1_i : pc_i;
    assign target_o = base + imm_i;

endmodule

// ==== rtl/exec_alu.sv ====
`timescale 1ns/10ps

module exec_alu import execute_pkg::*; #(
    parameter int XLEN = 32
) (
    input  exec_ctrl_t      ctrl_i,
    input  logic [XLEN-1:0] operand1_i,
    input  logic [XLEN-1:0] operand2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    output logic [XLEN-1:0] result_o
);

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign op_a  = ctrl_i.a_is_pc  ? pc_i  : operand1_i;
    assign op_b  = ctrl_i.b_is_imm ? imm_i : operand2_i;
    assign shamt = op_b[SHAMT_W-1:0]; // Upper bits of the amount are ignored.

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:  result_o = op_a + op_b;
            ALU_SUB:  result_o = op_a - op_b;
            ALU_XOR:  result_o = op_a ^ op_b;
            ALU_OR:   result_o = op_a | op_b;
            ALU_AND:  result_o = op_a & op_b;
            ALU_SLL:  result_o = op_a << shamt;
            ALU_SRL:  result_o = op_a >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== rtl/exec_ctrl.sv ====
`timescale 1ns/10ps

module exec_ctrl import execute_pkg::*; (
    input  logic       i_clk,
    input  logic       rst_n_i,
    input  logic       en_i,
    input  instr_e     instr_i,
    output exec_ctrl_t ctrl_o,
    output logic       valid_o
);

    always_comb begin
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.b_is_imm = 1'b0;
        ctrl_o.a_is_pc  = 1'b0;
        ctrl_o.cmp      = CMP_EQ;
        ctrl_o.res_sel  = RES_ZERO; // Unknown codes give zero.
        ctrl_o.sec_sel  = SEC_ZERO;

        // ALU op, shared by register and immediate forms.
        case (instr_i)
            INSTR_SUB:               ctrl_o.alu_op = ALU_SUB;
            INSTR_XOR,  INSTR_XORI:  ctrl_o.alu_op = ALU_XOR;
            INSTR_OR,   INSTR_ORI:   ctrl_o.alu_op = ALU_OR;
            INSTR_AND,  INSTR_ANDI:  ctrl_o.alu_op = ALU_AND;
            INSTR_SLL,  INSTR_SLLI:  ctrl_o.alu_op = ALU_SLL;
            INSTR_SRL,  INSTR_SRLI:  ctrl_o.alu_op = ALU_SRL;
            INSTR_SRA,  INSTR_SRAI:  ctrl_o.alu_op = ALU_SRA;
            INSTR_SLT,  INSTR_SLTI:  ctrl_o.alu_op = ALU_SLT;
            INSTR_SLTU, INSTR_SLTIU: ctrl_o.alu_op = ALU_SLTU;
            default:                 ctrl_o.alu_op = ALU_ADD; // Also address generation.
        endcase

        // Branch condition.
        case (instr_i)
            INSTR_BNE:  ctrl_o.cmp = CMP_NE;
            INSTR_BLT:  ctrl_o.cmp = CMP_LT;
            INSTR_BGE:  ctrl_o.cmp = CMP_GE;
            INSTR_BLTU: ctrl_o.cmp = CMP_LTU;
            INSTR_BGEU: ctrl_o.cmp = CMP_GEU;
            default:    ctrl_o.cmp = CMP_EQ;
        endcase

        // Operand and result routing per instruction class.
        case (instr_i)
            INSTR_ADD, INSTR_SUB, INSTR_XOR, INSTR_OR, INSTR_AND,
            INSTR_SLL, INSTR_SRL, INSTR_SRA, INSTR_SLT, INSTR_SLTU: begin
                ctrl_o.res_sel = RES_ALU;
            end
            INSTR_ADDI, INSTR_XORI, INSTR_ORI, INSTR_ANDI, INSTR_SLLI,
            INSTR_SRLI, INSTR_SRAI, INSTR_SLTI, INSTR_SLTIU,
            INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
            INSTR_SB, INSTR_SH, INSTR_SW: begin
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.res_sel  = RES_ALU;
            end
            INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE, INSTR_BLTU, INSTR_BGEU: begin
                ctrl_o.res_sel = RES_TAKEN;
                ctrl_o.sec_sel = SEC_PC_IMM;
            end
            INSTR_JAL: begin
                ctrl_o.res_sel = RES_LINK;
                ctrl_o.sec_sel = SEC_PC_IMM;
            end
            INSTR_JALR: begin
                ctrl_o.res_sel = RES_LINK;
                ctrl_o.sec_sel = SEC_RS1_IMM;
            end
            INSTR_AUIPC: begin
                ctrl_o.a_is_pc  = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.res_sel  = RES_ALU;
            end
            INSTR_LUI: ctrl_o.res_sel = RES_IMM;
            default:   ctrl_o.res_sel = RES_ZERO;
        endcase
    end

    always_ff @(posedge i_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= en_i; // Marks the result registered on this edge.
        end
    end

endmodule

// ==== rtl/execute_pkg.sv ====
package execute_pkg;

    parameter int XLEN    = 32;
    parameter int SHAMT_W = $clog2(XLEN); // Low bits of operand B used as shift amount.

    // Instructions kept in this stage, grouped by class.
    typedef enum logic [5:0] {
        INSTR_UNKNOWN = 6'd0,
        INSTR_ADD, INSTR_SUB, INSTR_XOR, INSTR_OR, INSTR_AND,
        INSTR_SLL, INSTR_SRL, INSTR_SRA, INSTR_SLT, INSTR_SLTU,
        INSTR_ADDI, INSTR_XORI, INSTR_ORI, INSTR_ANDI,
        INSTR_SLLI, INSTR_SRLI, INSTR_SRAI, INSTR_SLTI, INSTR_SLTIU,
        INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
        INSTR_SB, INSTR_SH, INSTR_SW,
        INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE, INSTR_BLTU, INSTR_BGEU,
        INSTR_JAL, INSTR_JALR,
        INSTR_LUI, INSTR_AUIPC
    } instr_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } cmp_e;

    // Source of the primary result.
    typedef enum logic [2:0] {
        RES_ALU,
        RES_LINK,
        RES_TAKEN,
        RES_IMM,
        RES_ZERO
    } res_sel_e;

    // Source of the secondary result, the jump or branch target.
    typedef enum logic [1:0] {
        SEC_ZERO,
        SEC_PC_IMM,
        SEC_RS1_IMM
    } sec_sel_e;

    typedef struct packed {
        instr_e            instr;
        logic [XLEN-1:0]   operand1;
        logic [XLEN-1:0]   operand2;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   pc;
    } exec_req_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     b_is_imm; // Operand B is the immediate.
        logic     a_is_pc;  // Operand A is the pc, for AUIPC.
        cmp_e     cmp;
        res_sel_e res_sel;
        sec_sel_e sec_sel;
    } exec_ctrl_t;

endpackage
